// File: verilog.f
axi_rd_pkg.sv
dma_rd_pkg.sv
burst_rd_if.sv
dma_rd_axi_master.sv
dma_rd_burst_ctrl.sv
dma_rd_fifo.sv
dma_rd_stream_out.sv
dma_rd_top.sv
dma_rd_tb_mem.sv
dma_rd_tb.sv

// File: Bender.yml
package:
  name: dma_rd

sources:
  - axi_rd_pkg.sv
  - dma_rd_pkg.sv
  - burst_rd_if.sv
  - dma_rd_axi_master.sv
  - dma_rd_burst_ctrl.sv
  - dma_rd_fifo.sv
  - dma_rd_stream_out.sv
  - dma_rd_top.sv
  - target: test
    files:
      - dma_rd_tb_mem.sv
      - dma_rd_tb.sv

// File: dma_rd_tb.sv
`timescale 1ns/10ps

module dma_rd_tb;

   localparam int TOTAL_WORDS = 5 + 50 + 40 + 0 + 24 + 24;
   localparam int RUNS        = 6;
   localparam int WATCHDOG_NS = (TOTAL_WORDS * 40 + RUNS * 200) * 10;

   logic        clk;
   logic        rst_n;
   logic        start;
   logic [31:0] addr;
   logic [15:0] length;
   logic [4:0]  max_len;
   logic        busy;
   logic [31:0] araddr;
   logic [7:0]  arlen;
   logic [1:0]  arburst;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic        rvalid;
   logic        rlast;
   logic        rready;
   logic [31:0] tdata;
   logic        tvalid;
   logic        tready;

   integer      seed = 32'ha9cf_2a1d;
   logic        rand_ready;
   int          errors = 0;
   int          failed_runs = 0;
   int          runs_done = 0;
   logic [31:0] exp_q[$];
   logic [31:0] ar_addr_q[$];
   int          ar_beats_q[$];
   int          ar_beat_sum = 0;
   logic        stall_q = 1'b0;
   logic [31:0] stall_data_q;

   dma_rd_top dut (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .start_i  (start),
      .addr_i   (addr),
      .length_i (length),
      .max_len_i(max_len),
      .busy_o   (busy),
      .araddr_o (araddr),
      .arlen_o  (arlen),
      .arburst_o(arburst),
      .arvalid_o(arvalid),
      .arready_i(arready),
      .rdata_i  (rdata),
      .rvalid_i (rvalid),
      .rlast_i  (rlast),
      .rready_o (rready),
      .tdata_o  (tdata),
      .tvalid_o (tvalid),
      .tready_i (tready)
   );

   dma_rd_tb_mem mem (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .araddr_i (araddr),
      .arlen_i  (arlen),
      .arvalid_i(arvalid),
      .arready_o(arready),
      .rdata_o  (rdata),
      .rvalid_o (rvalid),
      .rlast_o  (rlast),
      .rready_i (rready)
   );

   // Expected memory word for a byte address
   function automatic logic [31:0] expected_word(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      if (rand_ready) begin
         tready <= ($random(seed) & 1) != 0;
      end else begin
         tready <= 1'b1;
      end
   end

   // Stream checker sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n && stall_q) begin
         assert (tvalid && tdata == stall_data_q) else begin
            errors++;
            $display("FAIL at %0t: held word %h changed before tready", $time, stall_data_q);
         end
      end
      if (rst_n && tvalid && tready) begin
         assert (exp_q.size() > 0) else begin
            errors++;
            $display("extra stream word %h at %0t after the transfer was complete", tdata, $time);
         end
         if (exp_q.size() > 0) begin
            assert (tdata == exp_q[0]) else begin
               errors++;
               $display("FAIL at %0t: stream word %h, expected %h", $time, tdata, exp_q[0]);
            end
            void'(exp_q.pop_front());
         end
      end
      stall_q      = rst_n && tvalid && !tready;
      stall_data_q = tdata;
   end

   // AR request monitor
   always @(negedge clk) begin
      if (rst_n && arvalid && arready) begin
         assert (arburst == 2'b01) else begin
            errors++;
            $display("FAIL at %0t: arburst %b is not INCR", $time, arburst);
         end
         ar_addr_q.push_back(araddr);
         ar_beats_q.push_back(int'(arlen) + 1);
         ar_beat_sum = ar_beat_sum + int'(arlen) + 1;
      end
   end

   task automatic run_transfer(input string name, input logic [31:0] base, input int len,
                               input int max_beats, input logic rand_tready);
      int          err_start;
      int          wait_cycles;
      int          limit;
      int          beat_total;
      int          i;
      logic        busy_seen_low;
      logic [31:0] next_addr;

      err_start   = errors;
      limit       = len * 20 + 100;
      wait_cycles = 0;
      exp_q.delete();
      ar_addr_q.delete();
      ar_beats_q.delete();
      ar_beat_sum = 0;
      for (i = 0; i < len; i++) begin
         exp_q.push_back(expected_word(base + 32'(i) * 4));
      end
      rand_ready <= rand_tready;
      @(posedge clk);
      start   <= 1'b1;
      addr    <= base;
      length  <= 16'(len);
      max_len <= 5'(max_beats);
      @(posedge clk);
      start <= 1'b0;
      busy_seen_low = 1'b0;
      forever begin
         @(posedge clk);
         if (!busy && !busy_seen_low) begin
            busy_seen_low = 1'b1;
            // Every burst must have been requested before busy falls
            assert (ar_beat_sum == len) else begin
               errors++;
               $display("FAIL at %0t: busy low with %0d of %0d beats requested",
                        $time, ar_beat_sum, len);
            end
         end
         if (!busy && !tvalid && exp_q.size() == 0) break;
         if (wait_cycles == limit) begin
            errors++;
            $display("transfer %s did not complete within %0d cycles", name, limit);
            break;
         end
         wait_cycles++;
      end
      rand_ready <= 1'b0;

      next_addr  = base;
      beat_total = 0;
      for (i = 0; i < ar_addr_q.size(); i++) begin
         assert (ar_addr_q[i] == next_addr) else begin
            errors++;
            $display("FAIL at %0t: AR address %h, expected %h", $time, ar_addr_q[i], next_addr);
         end
         assert (ar_beats_q[i] <= max_beats) else begin
            errors++;
            $display("FAIL at %0t: burst of %0d beats exceeds max_len %0d",
                     $time, ar_beats_q[i], max_beats);
         end
         next_addr  = next_addr + 32'(ar_beats_q[i]) * 4;
         beat_total = beat_total + ar_beats_q[i];
      end
      assert (beat_total == len) else begin
         errors++;
         $display("FAIL at %0t: bursts cover %0d beats, expected %0d", $time, beat_total, len);
      end

      runs_done++;
      if (errors == err_start) begin
         $display("test %s: ok", name);
      end else begin
         failed_runs++;
         $display("test %s: %0d errors", name, errors - err_start);
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      start      = 1'b0;
      addr       = '0;
      length     = '0;
      max_len    = 5'd16;
      tready     = 1'b0;
      rand_ready = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (!busy && !arvalid && !tvalid && !rready) else begin
         errors++;
         $display("FAIL at %0t: outputs not idle after reset", $time);
      end

      run_transfer("single_burst", 32'h0000_1000, 5, 16, 1'b0);
      run_transfer("max_len_8", 32'h0000_2000, 50, 8, 1'b0);
      run_transfer("random_tready", 32'h0001_0040, 40, 16, 1'b1);
      run_transfer("zero_length", 32'h0000_3000, 0, 16, 1'b0);
      run_transfer("max_len_1", 32'h0000_4000, 24, 1, 1'b0);
      run_transfer("max_len_16", 32'h0000_4100, 24, 16, 1'b0);

      $display("runs %0d, failed %0d, errors %0d", runs_done, failed_runs, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: dma_rd_tb_mem.sv
`timescale 1ns/10ps

module dma_rd_tb_mem #(
   parameter int          ADDR_W = 32,
   parameter int          DATA_W = 32,
   parameter logic [31:0] SEED   = 32'ha9cf_2a1d
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [ADDR_W-1:0] araddr_i,
   input  logic [7:0]        arlen_i,
   input  logic              arvalid_i,
   output logic              arready_o,
   output logic [DATA_W-1:0] rdata_o,
   output logic              rvalid_o,
   output logic              rlast_o,
   input  logic              rready_i
);

   integer            seed = SEED;
   logic              active_q;
   logic [ADDR_W-1:0] addr_q;
   logic [7:0]        left_q;

   // Memory content is a hash of the byte address
   function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] a);
      return DATA_W'((32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f);
   endfunction

   assign rdata_o = word_at(addr_q);
   assign rlast_o = active_q && (left_q == '0);

   always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         active_q  <= 1'b0;
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         addr_q    <= '0;
         left_q    <= '0;
      end else if (!active_q) begin
         if (arvalid_i && arready_o) begin
            active_q  <= 1'b1;
            arready_o <= 1'b0;
            addr_q    <= araddr_i;
            left_q    <= arlen_i;
         end else begin
            arready_o <= ($random(seed) & 3) != 0;
         end
      end else if (rvalid_o && rready_i) begin
         if (left_q == '0) begin
            active_q <= 1'b0;
            rvalid_o <= 1'b0;
         end else begin
            addr_q   <= addr_q + ADDR_W'(DATA_W / 8);
            left_q   <= left_q - 1'b1;
            rvalid_o <= ($random(seed) & 3) != 0;
         end
      end else if (!rvalid_o) begin
         // Random gaps between beats
         rvalid_o <= ($random(seed) & 3) != 0;
      end
   end

endmodule

// File: dma_rd_top.sv
`timescale 1ns/10ps

module dma_rd_top #(
   parameter int AXI_ADDR_W = axi_rd_pkg::AXI_ADDR_W_DEF,
   parameter int AXI_DATA_W = axi_rd_pkg::AXI_DATA_W_DEF,
   parameter int AXI_LEN_W  = axi_rd_pkg::AXI_LEN_W_DEF,
   parameter int DMA_LEN_W  = dma_rd_pkg::DMA_LEN_W_DEF
) (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   // Transfer control
   input  logic                               start_i,
   input  logic [AXI_ADDR_W-1:0]              addr_i,
   input  logic [DMA_LEN_W-1:0]               length_i,
   input  logic [AXI_LEN_W:0]                 max_len_i,
   output logic                               busy_o,
   // AXI read address channel
   output logic [AXI_ADDR_W-1:0]              araddr_o,
   output logic [axi_rd_pkg::AXI_ARLEN_W-1:0] arlen_o,
   output logic [axi_rd_pkg::AXI_BURST_W-1:0] arburst_o,
   output logic                               arvalid_o,
   input  logic                               arready_i,
   // AXI read data channel
   input  logic [AXI_DATA_W-1:0]              rdata_i,
   input  logic                               rvalid_i,
   input  logic                               rlast_i,
   output logic                               rready_o,
   // Stream output
   output logic [AXI_DATA_W-1:0]              tdata_o,
   output logic                               tvalid_o,
   input  logic                               tready_i
);

   logic [AXI_DATA_W-1:0] fifo_wdata;
   logic                  fifo_wen;
   logic                  fifo_full;
   logic                  fifo_ren;
   logic [AXI_DATA_W-1:0] fifo_rdata;
   logic                  fifo_empty;
   logic [AXI_LEN_W:0]    fifo_level;

   burst_rd_if #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .AXI_LEN_W (AXI_LEN_W)
   ) burst_bus ();

   dma_rd_burst_ctrl #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .AXI_DATA_W(AXI_DATA_W),
      .AXI_LEN_W (AXI_LEN_W),
      .DMA_LEN_W (DMA_LEN_W)
   ) u_ctrl (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .start_i  (start_i),
      .addr_i   (addr_i),
      .length_i (length_i),
      .max_len_i(max_len_i),
      .level_i  (fifo_level),
      .busy_o   (busy_o),
      .burst    (burst_bus.ctrl)
   );

   dma_rd_axi_master #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .AXI_DATA_W(AXI_DATA_W),
      .AXI_LEN_W (AXI_LEN_W)
   ) u_master (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .burst       (burst_bus.master),
      .araddr_o    (araddr_o),
      .arlen_o     (arlen_o),
      .arburst_o   (arburst_o),
      .arvalid_o   (arvalid_o),
      .arready_i   (arready_i),
      .rdata_i     (rdata_i),
      .rvalid_i    (rvalid_i),
      .rlast_i     (rlast_i),
      .rready_o    (rready_o),
      .fifo_wdata_o(fifo_wdata),
      .fifo_wen_o  (fifo_wen),
      .fifo_full_i (fifo_full)
   );

   // Depth matches the longest burst
   dma_rd_fifo #(
      .DATA_W(AXI_DATA_W),
      .ADDR_W(AXI_LEN_W)
   ) u_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (fifo_wen),
      .w_data_i (fifo_wdata),
      .w_full_o (fifo_full),
      .r_en_i   (fifo_ren),
      .r_data_o (fifo_rdata),
      .r_empty_o(fifo_empty),
      .level_o  (fifo_level)
   );

   dma_rd_stream_out #(
      .DATA_W(AXI_DATA_W)
   ) u_stream (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .fifo_empty_i(fifo_empty),
      .fifo_rdata_i(fifo_rdata),
      .fifo_ren_o  (fifo_ren),
      .tdata_o     (tdata_o),
      .tvalid_o    (tvalid_o),
      .tready_i    (tready_i)
   );

endmodule

// File: dma_rd_stream_out.sv
`timescale 1ns/10ps

module dma_rd_stream_out #(
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              fifo_empty_i,
   input  logic [DATA_W-1:0] fifo_rdata_i,
   output logic              fifo_ren_o,
   output logic [DATA_W-1:0] tdata_o,
   output logic              tvalid_o,
   input  logic              tready_i
);

   // Set while the FIFO read port holds a word not yet taken
   logic              pend_q;
   logic              tvalid_q;
   logic [DATA_W-1:0] tdata_q;
   logic              load;

   // Output register is empty or drains this cycle
   assign load = pend_q && (!tvalid_q || tready_i);

   assign fifo_ren_o = !fifo_empty_i && (!pend_q || load);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q   <= 1'b0;
         tvalid_q <= 1'b0;
      end else begin
         if (fifo_ren_o) begin
            pend_q <= 1'b1;
         end else if (load) begin
            pend_q <= 1'b0;
         end
         if (load) begin
            tvalid_q <= 1'b1;
         end else if (tready_i) begin
            tvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) tdata_q <= fifo_rdata_i;
   end

   assign tvalid_o = tvalid_q;
   assign tdata_o  = tdata_q;

endmodule

// File: dma_rd_fifo.sv
`timescale 1ns/10ps

module dma_rd_fifo #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              w_en_i,
   input  logic [DATA_W-1:0] w_data_i,
   output logic              w_full_o,
   input  logic              r_en_i,
   output logic [DATA_W-1:0] r_data_o,
   output logic              r_empty_o,
   output logic [ADDR_W:0]   level_o
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [ADDR_W-1:0] wptr_q;
   logic [ADDR_W-1:0] rptr_q;
   logic [ADDR_W:0]   level_q;
   logic [DATA_W-1:0] rdata_q;
   logic              do_wr;
   logic              do_rd;

   assign w_full_o  = (level_q == (ADDR_W + 1)'(DEPTH));
   assign r_empty_o = (level_q == '0);

   // Overflowing writes and underflowing reads are dropped
   assign do_wr = w_en_i && !w_full_o;
   assign do_rd = r_en_i && !r_empty_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         if (do_wr) wptr_q <= wptr_q + 1'b1;
         if (do_rd) rptr_q <= rptr_q + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // Read data holds until the next read
   always_ff @(posedge clk_i) begin
      if (do_wr) mem[wptr_q] <= w_data_i;
      if (do_rd) rdata_q <= mem[rptr_q];
   end

   assign r_data_o = rdata_q;
   assign level_o  = level_q;

endmodule

// File: dma_rd_burst_ctrl.sv
`timescale 1ns/10ps

module dma_rd_burst_ctrl #(
   parameter int AXI_ADDR_W = axi_rd_pkg::AXI_ADDR_W_DEF,
   parameter int AXI_DATA_W = axi_rd_pkg::AXI_DATA_W_DEF,
   parameter int AXI_LEN_W  = axi_rd_pkg::AXI_LEN_W_DEF,
   parameter int DMA_LEN_W  = dma_rd_pkg::DMA_LEN_W_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  start_i,
   input  logic [AXI_ADDR_W-1:0] addr_i,
   input  logic [DMA_LEN_W-1:0]  length_i,
   input  logic [AXI_LEN_W:0]    max_len_i,
   input  logic [AXI_LEN_W:0]    level_i,
   output logic                  busy_o,
   burst_rd_if.ctrl              burst
);

   import dma_rd_pkg::*;

   localparam int FIFO_DEPTH     = 1 << AXI_LEN_W;
   localparam int BYTES_PER_BEAT = AXI_DATA_W / 8;
   localparam int BEAT_SHIFT     = $clog2(BYTES_PER_BEAT);

   ctrl_state_e           state_q;
   logic [DMA_LEN_W-1:0]  rem_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic                  start_q;
   logic [AXI_ADDR_W-1:0] burst_addr_q;
   logic [AXI_LEN_W:0]    burst_len_q;

   logic [AXI_LEN_W:0]    space;
   logic [DMA_LEN_W-1:0]  space_ext;
   logic [DMA_LEN_W-1:0]  max_ext;
   logic [AXI_LEN_W:0]    beats;
   logic                  master_free;
   logic                  fire;

   assign space     = (AXI_LEN_W + 1)'(FIFO_DEPTH) - level_i;
   assign space_ext = DMA_LEN_W'(space);
   assign max_ext   = DMA_LEN_W'(max_len_i);

   // A start pulse still in flight counts as a busy master
   assign master_free = !burst.busy && !start_q;

   always_comb begin
      beats = '0;
      if (rem_q != '0) begin
         if (rem_q <= space_ext && rem_q <= max_ext) begin
            beats = rem_q[AXI_LEN_W:0];
         end else if (space >= max_len_i) begin
            beats = max_len_i;
         end
      end
   end

   assign fire = (state_q == WAIT_SPACE) && master_free && (beats != '0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         rem_q   <= '0;
         start_q <= 1'b0;
      end else begin
         start_q <= fire;
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  rem_q   <= length_i;
                  state_q <= WAIT_SPACE;
               end
            end
            WAIT_SPACE: begin
               if (fire) begin
                  rem_q <= rem_q - DMA_LEN_W'(beats);
               end else if (rem_q == '0 && master_free) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && start_i) begin
         addr_q <= addr_i;
      end else if (fire) begin
         addr_q <= addr_q + (AXI_ADDR_W'(beats) << BEAT_SHIFT);
      end
      if (fire) begin
         burst_addr_q <= addr_q;
         burst_len_q  <= beats;
      end
   end

   assign burst.addr  = burst_addr_q;
   assign burst.len   = burst_len_q;
   assign burst.start = start_q;

   assign busy_o = (state_q != IDLE);

endmodule

// File: dma_rd_axi_master.sv
`timescale 1ns/10ps

module dma_rd_axi_master #(
   parameter int AXI_ADDR_W = axi_rd_pkg::AXI_ADDR_W_DEF,
   parameter int AXI_DATA_W = axi_rd_pkg::AXI_DATA_W_DEF,
   parameter int AXI_LEN_W  = axi_rd_pkg::AXI_LEN_W_DEF
) (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   burst_rd_if.master                         burst,
   output logic [AXI_ADDR_W-1:0]              araddr_o,
   output logic [axi_rd_pkg::AXI_ARLEN_W-1:0] arlen_o,
   output axi_rd_pkg::axi_burst_e             arburst_o,
   output logic                               arvalid_o,
   input  logic                               arready_i,
   input  logic [AXI_DATA_W-1:0]              rdata_i,
   input  logic                               rvalid_i,
   input  logic                               rlast_i,
   output logic                               rready_o,
   output logic [AXI_DATA_W-1:0]              fifo_wdata_o,
   output logic                               fifo_wen_o,
   input  logic                               fifo_full_i
);

   import axi_rd_pkg::*;
   import dma_rd_pkg::*;

   mst_state_e            state_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [AXI_LEN_W:0]    len_q;
   logic [AXI_LEN_W-1:0]  beats_m1;
   logic                  beat_acc;

   assign beat_acc = rvalid_i && rready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= AR_IDLE;
      end else begin
         case (state_q)
            AR_IDLE: if (burst.start) state_q <= AR_SEND;
            AR_SEND: if (arready_i) state_q <= R_RECV;
            R_RECV:  if (beat_acc && rlast_i) state_q <= AR_IDLE;
            default: state_q <= AR_IDLE;
         endcase
      end
   end

   // Request captured when the controller pulses start
   always_ff @(posedge clk_i) begin
      if (state_q == AR_IDLE && burst.start) begin
         addr_q <= burst.addr;
         len_q  <= burst.len;
      end
   end

   // AXI encodes beats minus one
   assign beats_m1 = AXI_LEN_W'(len_q - 1'b1);

   assign araddr_o  = addr_q;
   assign arlen_o   = AXI_ARLEN_W'(beats_m1);
   assign arburst_o = BURST_INCR;
   assign arvalid_o = (state_q == AR_SEND);

   // No beat is accepted unless the FIFO can take it
   assign rready_o     = (state_q == R_RECV) && !fifo_full_i;
   assign fifo_wen_o   = beat_acc;
   assign fifo_wdata_o = rdata_i;

   assign burst.busy = (state_q != AR_IDLE);

endmodule

// File: burst_rd_if.sv
`timescale 1ns/10ps

interface burst_rd_if #(
   parameter int AXI_ADDR_W = axi_rd_pkg::AXI_ADDR_W_DEF,
   parameter int AXI_LEN_W  = axi_rd_pkg::AXI_LEN_W_DEF
);

   logic [AXI_ADDR_W-1:0] addr;
   // Beats in the burst, 1 to 2**AXI_LEN_W
   logic [AXI_LEN_W:0]    len;
   logic                  start;
   logic                  busy;

   modport ctrl (
      output addr,
      output len,
      output start,
      input  busy
   );

   modport master (
      input  addr,
      input  len,
      input  start,
      output busy
   );

endinterface

// File: dma_rd_pkg.sv
package dma_rd_pkg;

   // Transfer length counted in data words
   localparam int DMA_LEN_W_DEF = 16;

   // Burst controller
   typedef enum logic {
      IDLE,
      WAIT_SPACE
   } ctrl_state_e;

   // AXI read master
   typedef enum logic [1:0] {
      AR_IDLE,
      AR_SEND,
      R_RECV
   } mst_state_e;

endpackage

// File: axi_rd_pkg.sv
package axi_rd_pkg;

   // Bus widths used when the top level is not overridden
   localparam int AXI_ADDR_W_DEF = 32;
   localparam int AXI_DATA_W_DEF = 32;

   // Up to 16 beats per burst and a 16 word buffer
   localparam int AXI_LEN_W_DEF = 4;

   // Fixed by the AXI4 spec
   localparam int AXI_ARLEN_W = 8;
   localparam int AXI_BURST_W = 2;

   typedef enum logic [AXI_BURST_W-1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01
   } axi_burst_e;

endpackage
